// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module id_tb -Mdir obj_dir

run: compile
	./obj_dir/Vid_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
+incdir+hdl
hdl/id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_top.sv
tb/id_assert.sv
tb/id_tb.sv

// File: hdl/branch_unit.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module branch_unit (
	input  logic [`ID_DATA_W-1:0] pc_i,
	input  id_pkg::inst_u         inst_i,
	input  id_pkg::dec_t          dec_i,
	input  logic [`ID_DATA_W-1:0] reg1_i,
	input  logic [`ID_DATA_W-1:0] reg2_i,
	output logic                  flag_o,
	output logic [`ID_DATA_W-1:0] addr_o,
	output logic [`ID_DATA_W-1:0] link_addr_o
);

	logic [`ID_DATA_W-1:0] pc_plus_4;
	logic [`ID_DATA_W-1:0] pc_plus_8;
	logic [`ID_DATA_W-1:0] br_offset;
	logic [`ID_DATA_W-1:0] target;
	logic taken;

	assign pc_plus_4 = pc_i + `ID_DATA_W'(4);
	assign pc_plus_8 = pc_i + `ID_DATA_W'(8);

	// word offset relative to the delay slot
	assign br_offset = {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};

	always_comb begin
		taken = 1'b0;
		target = pc_plus_4 + br_offset;
		case (dec_i.br_kind)
			id_pkg::BR_JUMP_IMM: begin
				taken = 1'b1;
				target = {pc_plus_4[31:28], inst_i.j.target26, 2'b00};
			end
			id_pkg::BR_JUMP_REG: begin
				taken = 1'b1;
				target = reg1_i;
			end
			id_pkg::BR_EQ: taken = (reg1_i == reg2_i);
			id_pkg::BR_NE: taken = (reg1_i != reg2_i);
			id_pkg::BR_GTZ: taken = ($signed(reg1_i) > 32'sd0);
			id_pkg::BR_LEZ: taken = ($signed(reg1_i) <= 32'sd0);
			id_pkg::BR_GEZ: taken = !reg1_i[`ID_DATA_W-1];
			id_pkg::BR_LTZ: taken = reg1_i[`ID_DATA_W-1];
			default: taken = 1'b0;
		endcase
	end

	assign flag_o = taken;
	assign addr_o = taken ? target : '0;

	// return address skips the delay slot
	assign link_addr_o = dec_i.link ? pc_plus_8 : '0;

endmodule

// File: hdl/id_ex_reg.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module id_ex_reg (
	input  logic                  clk,
	input  logic                  rst_i,
	input  id_pkg::dec_t          dec_i,
	input  logic [`ID_DATA_W-1:0] reg1_i,
	input  logic [`ID_DATA_W-1:0] reg2_i,
	input  logic                  br_flag_i,
	input  logic [`ID_DATA_W-1:0] br_addr_i,
	input  logic [`ID_DATA_W-1:0] link_addr_i,
	output id_pkg::id_ex_t        id_ex_o,
	output id_pkg::branch_t       branch_o
);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			// bubble into ex
			id_ex_o.aluop <= id_pkg::ALU_NOP;
			id_ex_o.alusel <= id_pkg::SEL_NOP;
			id_ex_o.reg1 <= '0;
			id_ex_o.reg2 <= '0;
			id_ex_o.wd <= '0;
			id_ex_o.wreg <= 1'b0;
			id_ex_o.link_addr <= '0;
			branch_o.flag <= 1'b0;
			branch_o.addr <= '0;
		end else begin
			id_ex_o.aluop <= dec_i.aluop;
			id_ex_o.alusel <= dec_i.alusel;
			id_ex_o.reg1 <= reg1_i;
			id_ex_o.reg2 <= reg2_i;
			id_ex_o.wd <= dec_i.wd;
			id_ex_o.wreg <= dec_i.wreg;
			id_ex_o.link_addr <= link_addr_i;
			branch_o.flag <= br_flag_i;
			branch_o.addr <= br_addr_i;
		end
	end

endmodule

// File: hdl/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// data and address words
`define ID_DATA_W 32

// register file index
`define ID_REG_AW 5

// written by jal and the linking branches
`define ID_LINK_REG 31

// shamt field of the R format
`define ID_SHAMT_W 5

`endif

// File: hdl/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

	// three views of the same instruction word
	typedef struct packed {
		logic [5:0] op;
		logic [`ID_REG_AW-1:0] rs;
		logic [`ID_REG_AW-1:0] rt;
		logic [`ID_REG_AW-1:0] rd;
		logic [`ID_SHAMT_W-1:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [`ID_REG_AW-1:0] rs;
		logic [`ID_REG_AW-1:0] rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_u;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// rt field under REGIMM
	typedef enum logic [`ID_REG_AW-1:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

	typedef enum logic [7:0] {
		ALU_NOP    = 8'b00000000,
		ALU_AND    = 8'b00100100,
		ALU_OR     = 8'b00100101,
		ALU_XOR    = 8'b00100110,
		ALU_NOR    = 8'b00100111,
		ALU_SLL    = 8'b01111100,
		ALU_SRL    = 8'b00000010,
		ALU_SRA    = 8'b00000011,
		ALU_ADD    = 8'b00100000,
		ALU_ADDU   = 8'b00100001,
		ALU_ADDI   = 8'b01010101,
		ALU_ADDIU  = 8'b01010110,
		ALU_SUB    = 8'b00100010,
		ALU_SUBU   = 8'b00100011,
		ALU_SLT    = 8'b00101010,
		ALU_SLTU   = 8'b00101011,
		ALU_J      = 8'b01001111,
		ALU_JAL    = 8'b01010000,
		ALU_JR     = 8'b00001000,
		ALU_JALR   = 8'b00001001,
		ALU_BEQ    = 8'b01010001,
		ALU_BNE    = 8'b01010010,
		ALU_BGTZ   = 8'b01010100,
		ALU_BLEZ   = 8'b01010011,
		ALU_BGEZ   = 8'b01000001,
		ALU_BLTZ   = 8'b01000000,
		ALU_BGEZAL = 8'b01001011,
		ALU_BLTZAL = 8'b01001010
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alusel_e;

	typedef enum logic [3:0] {
		BR_NONE,
		BR_JUMP_IMM,
		BR_JUMP_REG,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} br_kind_e;

	// write-back seen from a later stage
	typedef struct packed {
		logic wreg;
		logic [`ID_REG_AW-1:0] wd;
		logic [`ID_DATA_W-1:0] wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e aluop;
		alusel_e alusel;
		logic wreg;
		logic [`ID_REG_AW-1:0] wd;
		logic reg1_read;
		logic reg2_read;
		logic [`ID_DATA_W-1:0] imm;
		br_kind_e br_kind;
		logic link;
	} dec_t;

	typedef struct packed {
		aluop_e aluop;
		alusel_e alusel;
		logic [`ID_DATA_W-1:0] reg1;
		logic [`ID_DATA_W-1:0] reg2;
		logic [`ID_REG_AW-1:0] wd;
		logic wreg;
		logic [`ID_DATA_W-1:0] link_addr;
	} id_ex_t;

	typedef struct packed {
		logic flag;
		logic [`ID_DATA_W-1:0] addr;
	} branch_t;

endpackage

// File: hdl/id_top.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module id_top (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic [`ID_DATA_W-1:0] pc_i,
	input  id_pkg::inst_u         inst_i,
	input  logic [`ID_DATA_W-1:0] reg1_data_i,
	input  logic [`ID_DATA_W-1:0] reg2_data_i,
	input  id_pkg::fwd_t          ex_fwd_i,
	input  id_pkg::fwd_t          mem_fwd_i,
	output logic                  reg1_read_o,
	output logic                  reg2_read_o,
	output logic [`ID_REG_AW-1:0] reg1_addr_o,
	output logic [`ID_REG_AW-1:0] reg2_addr_o,
	output id_pkg::id_ex_t        id_ex_o,
	output id_pkg::branch_t       branch_o
);

	id_pkg::dec_t dec;
	logic [`ID_DATA_W-1:0] reg1;
	logic [`ID_DATA_W-1:0] reg2;
	logic br_flag;
	logic [`ID_DATA_W-1:0] br_addr;
	logic [`ID_DATA_W-1:0] link_addr;

	// register file read port, rs and rt
	assign reg1_read_o = dec.reg1_read;
	assign reg2_read_o = dec.reg2_read;
	assign reg1_addr_o = inst_i.r.rs;
	assign reg2_addr_o = inst_i.r.rt;

	inst_decoder u_dec (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	operand_forward op1_fwd (
		.read_i    (dec.reg1_read),
		.addr_i    (inst_i.r.rs),
		.rf_data_i (reg1_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.data_o    (reg1)
	);

	operand_forward op2_fwd (
		.read_i    (dec.reg2_read),
		.addr_i    (inst_i.r.rt),
		.rf_data_i (reg2_data_i),
		.imm_i     (dec.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.data_o    (reg2)
	);

	branch_unit u_br (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.flag_o      (br_flag),
		.addr_o      (br_addr),
		.link_addr_o (link_addr)
	);

	id_ex_reg u_id_ex (
		.clk         (clk),
		.rst_i       (rst_i),
		.dec_i       (dec),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.br_flag_i   (br_flag),
		.br_addr_i   (br_addr),
		.link_addr_i (link_addr),
		.id_ex_o     (id_ex_o),
		.branch_o    (branch_o)
	);

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module inst_decoder (
	input  id_pkg::inst_u inst_i,
	output id_pkg::dec_t  dec_o
);

	function automatic id_pkg::dec_t nop_dec();
		id_pkg::dec_t d;
		d = '0;
		d.aluop = id_pkg::ALU_NOP;
		d.alusel = id_pkg::SEL_NOP;
		d.br_kind = id_pkg::BR_NONE;
		return d;
	endfunction

	logic [`ID_DATA_W-1:0] imm_sext;
	logic [`ID_DATA_W-1:0] imm_zext;
	logic shift_imm;

	assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_zext = {16'h0, inst_i.i.imm16};

	// shift amount comes from the shamt field
	assign shift_imm = (inst_i.r.funct == id_pkg::FN_SLL) ||
		(inst_i.r.funct == id_pkg::FN_SRL) ||
		(inst_i.r.funct == id_pkg::FN_SRA);

	always_comb begin
		dec_o = nop_dec();
		case (inst_i.i.op)
			id_pkg::OP_SPECIAL: begin
				dec_o.wreg = 1'b1;
				dec_o.wd = inst_i.r.rd;
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;
				case (inst_i.r.funct)
					id_pkg::FN_AND: dec_o.aluop = id_pkg::ALU_AND;
					id_pkg::FN_OR: dec_o.aluop = id_pkg::ALU_OR;
					id_pkg::FN_XOR: dec_o.aluop = id_pkg::ALU_XOR;
					id_pkg::FN_NOR: dec_o.aluop = id_pkg::ALU_NOR;
					id_pkg::FN_SLL, id_pkg::FN_SLLV: dec_o.aluop = id_pkg::ALU_SLL;
					id_pkg::FN_SRL, id_pkg::FN_SRLV: dec_o.aluop = id_pkg::ALU_SRL;
					id_pkg::FN_SRA, id_pkg::FN_SRAV: dec_o.aluop = id_pkg::ALU_SRA;
					id_pkg::FN_ADD: dec_o.aluop = id_pkg::ALU_ADD;
					id_pkg::FN_ADDU: dec_o.aluop = id_pkg::ALU_ADDU;
					id_pkg::FN_SUB: dec_o.aluop = id_pkg::ALU_SUB;
					id_pkg::FN_SUBU: dec_o.aluop = id_pkg::ALU_SUBU;
					id_pkg::FN_SLT: dec_o.aluop = id_pkg::ALU_SLT;
					id_pkg::FN_SLTU: dec_o.aluop = id_pkg::ALU_SLTU;
					id_pkg::FN_JR: dec_o.aluop = id_pkg::ALU_JR;
					id_pkg::FN_JALR: dec_o.aluop = id_pkg::ALU_JALR;
					default: dec_o.aluop = id_pkg::ALU_NOP;
				endcase
				case (inst_i.r.funct)
					id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR:
						dec_o.alusel = id_pkg::SEL_LOGIC;
					id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA,
					id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV:
						dec_o.alusel = id_pkg::SEL_SHIFT;
					id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB,
					id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU:
						dec_o.alusel = id_pkg::SEL_ARITH;
					id_pkg::FN_JR, id_pkg::FN_JALR:
						dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
					default: dec_o.alusel = id_pkg::SEL_NOP;
				endcase
				if (shift_imm) begin
					dec_o.reg1_read = 1'b0;
					dec_o.imm = {{(`ID_DATA_W - `ID_SHAMT_W){1'b0}}, inst_i.r.shamt};
				end
				// register jumps, jalr links into rd
				if (dec_o.alusel == id_pkg::SEL_JUMP_BRANCH) begin
					dec_o.reg2_read = 1'b0;
					dec_o.br_kind = id_pkg::BR_JUMP_REG;
					dec_o.wreg = (inst_i.r.funct == id_pkg::FN_JALR);
					dec_o.link = (inst_i.r.funct == id_pkg::FN_JALR);
				end
				// rs must be 0 on shamt shifts, shamt 0 elsewhere
				if (dec_o.aluop == id_pkg::ALU_NOP ||
					(shift_imm ? inst_i.r.rs != '0 : inst_i.r.shamt != '0)) begin
					dec_o = nop_dec();
				end
			end
			id_pkg::OP_REGIMM: begin
				dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
				dec_o.reg1_read = 1'b1;
				case (inst_i.i.rt)
					id_pkg::RI_BLTZ: begin
						dec_o.aluop = id_pkg::ALU_BLTZ;
						dec_o.br_kind = id_pkg::BR_LTZ;
					end
					id_pkg::RI_BGEZ: begin
						dec_o.aluop = id_pkg::ALU_BGEZ;
						dec_o.br_kind = id_pkg::BR_GEZ;
					end
					id_pkg::RI_BLTZAL, id_pkg::RI_BGEZAL: begin
						dec_o.aluop = inst_i.i.rt[0] ? id_pkg::ALU_BGEZAL : id_pkg::ALU_BLTZAL;
						dec_o.br_kind = inst_i.i.rt[0] ? id_pkg::BR_GEZ : id_pkg::BR_LTZ;
						dec_o.wreg = 1'b1;
						dec_o.wd = `ID_REG_AW'(`ID_LINK_REG);
						dec_o.link = 1'b1;
					end
					default: dec_o = nop_dec();
				endcase
			end
			id_pkg::OP_J, id_pkg::OP_JAL: begin
				dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
				dec_o.br_kind = id_pkg::BR_JUMP_IMM;
				if (inst_i.j.op == id_pkg::OP_JAL) begin
					dec_o.aluop = id_pkg::ALU_JAL;
					dec_o.wreg = 1'b1;
					dec_o.wd = `ID_REG_AW'(`ID_LINK_REG);
					dec_o.link = 1'b1;
				end else begin
					dec_o.aluop = id_pkg::ALU_J;
				end
			end
			id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
				dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;
				dec_o.aluop = inst_i.i.op[0] ? id_pkg::ALU_BNE : id_pkg::ALU_BEQ;
				dec_o.br_kind = inst_i.i.op[0] ? id_pkg::BR_NE : id_pkg::BR_EQ;
			end
			id_pkg::OP_BLEZ, id_pkg::OP_BGTZ: begin
				dec_o.alusel = id_pkg::SEL_JUMP_BRANCH;
				dec_o.reg1_read = 1'b1;
				dec_o.aluop = inst_i.i.op[0] ? id_pkg::ALU_BGTZ : id_pkg::ALU_BLEZ;
				dec_o.br_kind = inst_i.i.op[0] ? id_pkg::BR_GTZ : id_pkg::BR_LEZ;
			end
			id_pkg::OP_ANDI, id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI,
			id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
				// I format writes rt, second operand is the immediate
				dec_o.wreg = 1'b1;
				dec_o.wd = inst_i.i.rt;
				dec_o.reg1_read = 1'b1;
				dec_o.alusel = inst_i.i.op[2] ? id_pkg::SEL_LOGIC : id_pkg::SEL_ARITH;
				dec_o.imm = inst_i.i.op[2] ? imm_zext : imm_sext;
				case (inst_i.i.op)
					id_pkg::OP_ANDI: dec_o.aluop = id_pkg::ALU_AND;
					id_pkg::OP_ORI: dec_o.aluop = id_pkg::ALU_OR;
					id_pkg::OP_XORI: dec_o.aluop = id_pkg::ALU_XOR;
					id_pkg::OP_ADDI: dec_o.aluop = id_pkg::ALU_ADDI;
					id_pkg::OP_ADDIU: dec_o.aluop = id_pkg::ALU_ADDIU;
					id_pkg::OP_SLTI: dec_o.aluop = id_pkg::ALU_SLT;
					id_pkg::OP_SLTIU: dec_o.aluop = id_pkg::ALU_SLTU;
					default: begin
						// lui is an or with the upper half
						dec_o.aluop = id_pkg::ALU_OR;
						dec_o.imm = {inst_i.i.imm16, 16'h0};
					end
				endcase
			end
			default: dec_o = nop_dec();
		endcase
	end

endmodule

// File: hdl/operand_forward.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module operand_forward (
	input  logic                  read_i,
	input  logic [`ID_REG_AW-1:0] addr_i,
	input  logic [`ID_DATA_W-1:0] rf_data_i,
	input  logic [`ID_DATA_W-1:0] imm_i,
	input  id_pkg::fwd_t          ex_fwd_i,
	input  id_pkg::fwd_t          mem_fwd_i,
	output logic [`ID_DATA_W-1:0] data_o
);

	// youngest result wins: ex, then mem, then register file
	always_comb begin
		if (!read_i) begin
			data_o = imm_i;
		end else if (ex_fwd_i.wreg && ex_fwd_i.wd == addr_i) begin
			data_o = ex_fwd_i.wdata;
		end else if (mem_fwd_i.wreg && mem_fwd_i.wd == addr_i) begin
			data_o = mem_fwd_i.wdata;
		end else begin
			data_o = rf_data_i;
		end
	end

endmodule

// File: tb/id_assert.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module id_assert (
	input logic            clk,
	input logic            rst_i,
	input id_pkg::inst_u   inst_i,
	input logic            reg1_read_o,
	input id_pkg::id_ex_t  id_ex_o,
	input id_pkg::branch_t branch_o
);

	// bubble for every cycle following a reset cycle
	a_reset_bubble: assert property (@(posedge clk) rst_i |=> (!id_ex_o.wreg && !branch_o.flag))
		else $error("id_ex_o not cleared by reset");

	a_not_taken_zero: assert property (@(posedge clk) disable iff (rst_i)
		!branch_o.flag |-> branch_o.addr == '0)
		else $error("branch address set without a taken branch");

	// shamt shifts take the first operand from the immediate
	a_shift_no_read: assert property (@(posedge clk) (inst_i.r.op == 6'd0 &&
		(inst_i.r.funct == 6'h00 || inst_i.r.funct == 6'h02 || inst_i.r.funct == 6'h03))
		|-> !reg1_read_o)
		else $error("reg1 read on a shamt shift");

endmodule

bind id_top id_assert u_assert (
	.clk         (clk),
	.rst_i       (rst_i),
	.inst_i      (inst_i),
	.reg1_read_o (reg1_read_o),
	.id_ex_o     (id_ex_o),
	.branch_o    (branch_o)
);

// File: tb/id_tb.sv
`timescale 1ns/10ps
`include "id_macros.svh"

module id_tb;

	localparam int N_RAND = 300;
	localparam int N_DIRECTED = 40;
	localparam int N_TESTS = N_RAND + N_DIRECTED;

	typedef struct packed {
		id_pkg::id_ex_t id_ex;
		id_pkg::branch_t br;
		logic rd1;
		logic rd2;
		logic [4:0] a1;
		logic [4:0] a2;
	} exp_t;

	logic clk;
	logic rst_i;
	logic [31:0] pc_i;
	id_pkg::inst_u inst_i;
	logic [31:0] reg1_data_i;
	logic [31:0] reg2_data_i;
	id_pkg::fwd_t ex_fwd_i;
	id_pkg::fwd_t mem_fwd_i;
	logic reg1_read_o;
	logic reg2_read_o;
	logic [4:0] reg1_addr_o;
	logic [4:0] reg2_addr_o;
	id_pkg::id_ex_t id_ex_o;
	id_pkg::branch_t branch_o;

	integer seed = 32'hd266;
	int errors = 0;
	logic check_en = 1'b0;
	exp_t cur_exp;

	id_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#((N_TESTS + 20) * 10);
		$display("timeout: the run did not finish in time");
		$display("Verification failed");
		$finish;
	end

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_outputs(input exp_t e, input logic with_reads);
		compare("id_ex_o.aluop", 32'(e.id_ex.aluop), 32'(id_ex_o.aluop));
		compare("id_ex_o.alusel", 32'(e.id_ex.alusel), 32'(id_ex_o.alusel));
		compare("id_ex_o.reg1", e.id_ex.reg1, id_ex_o.reg1);
		compare("id_ex_o.reg2", e.id_ex.reg2, id_ex_o.reg2);
		compare("id_ex_o.wd", 32'(e.id_ex.wd), 32'(id_ex_o.wd));
		compare("id_ex_o.wreg", 32'(e.id_ex.wreg), 32'(id_ex_o.wreg));
		compare("id_ex_o.link_addr", e.id_ex.link_addr, id_ex_o.link_addr);
		compare("branch_o.flag", 32'(e.br.flag), 32'(branch_o.flag));
		compare("branch_o.addr", e.br.addr, branch_o.addr);
		if (with_reads) begin
			compare("reg1_read_o", 32'(e.rd1), 32'(reg1_read_o));
			compare("reg2_read_o", 32'(e.rd2), 32'(reg2_read_o));
			compare("reg1_addr_o", 32'(e.a1), 32'(reg1_addr_o));
			compare("reg2_addr_o", 32'(e.a2), 32'(reg2_addr_o));
		end
	endtask

	// ex result beats mem result beats register file
	function automatic logic [31:0] pick_source(input logic [4:0] a, input logic [31:0] rf,
			input id_pkg::fwd_t ex, input id_pkg::fwd_t mem);
		if (ex.wreg && ex.wd == a)
			return ex.wdata;
		if (mem.wreg && mem.wd == a)
			return mem.wdata;
		return rf;
	endfunction

	function automatic exp_t expected_out(input logic [31:0] pc, input id_pkg::inst_u in,
			input logic [31:0] rf1, input logic [31:0] rf2,
			input id_pkg::fwd_t ex, input id_pkg::fwd_t mem);
		exp_t e;
		id_pkg::aluop_e op;
		id_pkg::alusel_e sel;
		id_pkg::br_kind_e kind;
		logic wreg;
		logic [4:0] wd;
		logic rd1;
		logic rd2;
		logic link;
		logic ok;
		logic taken;
		logic [31:0] imm;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] pc4;
		logic [31:0] target;
		op = id_pkg::ALU_NOP;
		sel = id_pkg::SEL_NOP;
		kind = id_pkg::BR_NONE;
		{wreg, wd, rd1, rd2, link, imm} = '0;
		ok = 1'b1;
		case (in.r.op)
			6'd0: begin
				{wreg, wd, rd1, rd2} = {1'b1, in.r.rd, 2'b11};
				case (in.r.funct)
					6'h24: {op, sel} = {id_pkg::ALU_AND, id_pkg::SEL_LOGIC};
					6'h25: {op, sel} = {id_pkg::ALU_OR, id_pkg::SEL_LOGIC};
					6'h26: {op, sel} = {id_pkg::ALU_XOR, id_pkg::SEL_LOGIC};
					6'h27: {op, sel} = {id_pkg::ALU_NOR, id_pkg::SEL_LOGIC};
					6'h00, 6'h04: {op, sel} = {id_pkg::ALU_SLL, id_pkg::SEL_SHIFT};
					6'h02, 6'h06: {op, sel} = {id_pkg::ALU_SRL, id_pkg::SEL_SHIFT};
					6'h03, 6'h07: {op, sel} = {id_pkg::ALU_SRA, id_pkg::SEL_SHIFT};
					6'h20: {op, sel} = {id_pkg::ALU_ADD, id_pkg::SEL_ARITH};
					6'h21: {op, sel} = {id_pkg::ALU_ADDU, id_pkg::SEL_ARITH};
					6'h22: {op, sel} = {id_pkg::ALU_SUB, id_pkg::SEL_ARITH};
					6'h23: {op, sel} = {id_pkg::ALU_SUBU, id_pkg::SEL_ARITH};
					6'h2a: {op, sel} = {id_pkg::ALU_SLT, id_pkg::SEL_ARITH};
					6'h2b: {op, sel} = {id_pkg::ALU_SLTU, id_pkg::SEL_ARITH};
					6'h08, 6'h09: begin
						op = in.r.funct[0] ? id_pkg::ALU_JALR : id_pkg::ALU_JR;
						sel = id_pkg::SEL_JUMP_BRANCH;
						kind = id_pkg::BR_JUMP_REG;
						rd2 = 1'b0;
						wreg = in.r.funct[0];
						link = in.r.funct[0];
					end
					default: ok = 1'b0;
				endcase
				if (in.r.funct == 6'h00 || in.r.funct == 6'h02 || in.r.funct == 6'h03) begin
					rd1 = 1'b0;
					imm = 32'(in.r.shamt);
					ok = ok && (in.r.rs == 5'd0);
				end else begin
					ok = ok && (in.r.shamt == 5'd0);
				end
			end
			6'd1: begin
				{sel, rd1} = {id_pkg::SEL_JUMP_BRANCH, 1'b1};
				case (in.i.rt)
					5'd0: {op, kind} = {id_pkg::ALU_BLTZ, id_pkg::BR_LTZ};
					5'd1: {op, kind} = {id_pkg::ALU_BGEZ, id_pkg::BR_GEZ};
					5'd16: {op, kind} = {id_pkg::ALU_BLTZAL, id_pkg::BR_LTZ};
					5'd17: {op, kind} = {id_pkg::ALU_BGEZAL, id_pkg::BR_GEZ};
					default: ok = 1'b0;
				endcase
				if (in.i.rt[4])
					{wreg, wd, link} = {1'b1, 5'd31, 1'b1};
			end
			6'd2: {op, sel, kind} = {id_pkg::ALU_J, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_JUMP_IMM};
			6'd3: begin
				{op, sel, kind} = {id_pkg::ALU_JAL, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_JUMP_IMM};
				{wreg, wd, link} = {1'b1, 5'd31, 1'b1};
			end
			6'd4: {op, sel, kind, rd1, rd2} =
				{id_pkg::ALU_BEQ, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_EQ, 2'b11};
			6'd5: {op, sel, kind, rd1, rd2} =
				{id_pkg::ALU_BNE, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_NE, 2'b11};
			6'd6: {op, sel, kind, rd1} =
				{id_pkg::ALU_BLEZ, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_LEZ, 1'b1};
			6'd7: {op, sel, kind, rd1} =
				{id_pkg::ALU_BGTZ, id_pkg::SEL_JUMP_BRANCH, id_pkg::BR_GTZ, 1'b1};
			6'd8, 6'd9, 6'd10, 6'd11: begin
				{wreg, wd, rd1, sel} = {1'b1, in.i.rt, 1'b1, id_pkg::SEL_ARITH};
				imm = {{16{in.i.imm16[15]}}, in.i.imm16};
				case (in.i.op[1:0])
					2'd0: op = id_pkg::ALU_ADDI;
					2'd1: op = id_pkg::ALU_ADDIU;
					2'd2: op = id_pkg::ALU_SLT;
					default: op = id_pkg::ALU_SLTU;
				endcase
			end
			6'd12, 6'd13, 6'd14, 6'd15: begin
				{wreg, wd, rd1, sel} = {1'b1, in.i.rt, 1'b1, id_pkg::SEL_LOGIC};
				imm = {16'h0, in.i.imm16};
				case (in.i.op[1:0])
					2'd0: op = id_pkg::ALU_AND;
					2'd1: op = id_pkg::ALU_OR;
					2'd2: op = id_pkg::ALU_XOR;
					default: begin
						op = id_pkg::ALU_OR;
						imm = {in.i.imm16, 16'h0};
					end
				endcase
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			op = id_pkg::ALU_NOP;
			sel = id_pkg::SEL_NOP;
			kind = id_pkg::BR_NONE;
			{wreg, wd, rd1, rd2, link, imm} = '0;
		end
		op1 = rd1 ? pick_source(in.r.rs, rf1, ex, mem) : imm;
		op2 = rd2 ? pick_source(in.r.rt, rf2, ex, mem) : imm;
		pc4 = pc + 32'd4;
		target = pc4 + {{14{in.i.imm16[15]}}, in.i.imm16, 2'b00};
		case (kind)
			id_pkg::BR_JUMP_IMM: {taken, target} = {1'b1, pc4[31:28], in.j.target26, 2'b00};
			id_pkg::BR_JUMP_REG: {taken, target} = {1'b1, op1};
			id_pkg::BR_EQ: taken = (op1 == op2);
			id_pkg::BR_NE: taken = (op1 != op2);
			id_pkg::BR_GTZ: taken = ($signed(op1) > 0);
			id_pkg::BR_LEZ: taken = ($signed(op1) <= 0);
			id_pkg::BR_GEZ: taken = ($signed(op1) >= 0);
			id_pkg::BR_LTZ: taken = ($signed(op1) < 0);
			default: taken = 1'b0;
		endcase
		e.id_ex = '{op, sel, op1, op2, wd, wreg, link ? pc + 32'd8 : 32'd0};
		e.br = '{taken, taken ? target : 32'd0};
		{e.rd1, e.rd2, e.a1, e.a2} = {rd1, rd2, in.r.rs, in.r.rt};
		return e;
	endfunction

	function automatic int rnd(input int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	function automatic id_pkg::inst_u r_format(input logic [5:0] fn, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'd0, rs, rt, rd, sh, fn};
	endfunction

	function automatic id_pkg::inst_u i_format(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic id_pkg::fwd_t writeback(input logic w, input logic [4:0] wd,
			input logic [31:0] data);
		return {w, wd, data};
	endfunction

	function automatic id_pkg::inst_u random_inst();
		logic [5:0] fns [18] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09,
			6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
		logic [5:0] brs [5] = '{6'd1, 6'd4, 6'd5, 6'd6, 6'd7};
		logic [4:0] ris [4] = '{5'd0, 5'd1, 5'd16, 5'd17};
		logic [5:0] fn;
		logic [5:0] op;
		case (rnd(4))
			0: begin
				fn = fns[rnd(18)];
				if (fn == 6'h00 || fn == 6'h02 || fn == 6'h03)
					return r_format(fn, 5'd0, 5'(rnd(4)), 5'(rnd(8)), 5'(rnd(32)));
				return r_format(fn, 5'(rnd(4)), 5'(rnd(4)), 5'(rnd(8)), 5'd0);
			end
			1: return i_format(6'(8 + rnd(8)), 5'(rnd(4)), 5'(rnd(4)), 16'($random(seed)));
			2: begin
				op = brs[rnd(5)];
				return i_format(op, 5'(rnd(4)), op == 6'd1 ? ris[rnd(4)] : 5'(rnd(4)),
					16'($random(seed)));
			end
			default: return {6'(2 + rnd(2)), 26'($random(seed))};
		endcase
	endfunction

	// one instruction per falling edge, expected result computed alongside
	task automatic drive(input logic [31:0] pc, input id_pkg::inst_u in, input logic [31:0] r1,
			input logic [31:0] r2, input id_pkg::fwd_t ex, input id_pkg::fwd_t mem);
		@(negedge clk);
		{pc_i, inst_i, reg1_data_i, reg2_data_i, ex_fwd_i, mem_fwd_i} = {pc, in, r1, r2, ex, mem};
		cur_exp = expected_out(pc, in, r1, r2, ex, mem);
		check_en = 1'b1;
	endtask

	// registered results of the last edge, read ports of the held inputs
	always @(posedge clk) begin
		#1;
		if (check_en)
			check_outputs(cur_exp, 1'b1);
	end

	initial begin
		id_pkg::fwd_t none;
		logic [31:0] vals [4];
		none = '0;
		vals = '{32'd0, 32'd77, 32'hffff_fff0, 32'd77};
		{rst_i, pc_i, inst_i, reg1_data_i, reg2_data_i, ex_fwd_i, mem_fwd_i} = '0;
		rst_i = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		check_outputs('0, 1'b0);
		@(negedge clk);
		rst_i = 1'b0;
		// forwarding priority on ADD r1, r2 -> r3
		drive(32'h100, r_format(6'h20, 5'd1, 5'd2, 5'd3, 5'd0), 32'h11, 32'h22,
			writeback(1, 5'd1, 32'hea), writeback(1, 5'd1, 32'hda));
		drive(32'h104, r_format(6'h20, 5'd1, 5'd2, 5'd3, 5'd0), 32'h11, 32'h22,
			writeback(1, 5'd2, 32'heb), writeback(1, 5'd2, 32'hdb));
		drive(32'h108, r_format(6'h20, 5'd1, 5'd2, 5'd3, 5'd0), 32'h11, 32'h22,
			writeback(0, 5'd1, 32'hec), writeback(1, 5'd1, 32'hdc));
		drive(32'h10c, r_format(6'h20, 5'd1, 5'd2, 5'd3, 5'd0), 32'h11, 32'h22,
			writeback(0, 5'd1, 32'hed), writeback(0, 5'd2, 32'hdd));
		drive(32'h110, i_format(6'd15, 5'd0, 5'd4, 16'hbeef), 0, 0, none, none);
		drive(32'h114, r_format(6'h03, 5'd0, 5'd2, 5'd5, 5'd7), 0, 32'h8000_0000, none, none);
		// conditional branches over zero, positive, negative and equal
		for (int k = 0; k < 4; k++) begin
			drive(32'h200, i_format(6'd4, 5'd1, 5'd2, 16'hfffc), vals[k], 32'd77, none, none);
			drive(32'h204, i_format(6'd5, 5'd1, 5'd2, 16'h0010), vals[k], 32'd77, none, none);
			drive(32'h208, i_format(6'd7, 5'd1, 5'd0, 16'h0020), vals[k], 0, none, none);
			drive(32'h20c, i_format(6'd6, 5'd1, 5'd0, 16'h8000), vals[k], 0, none, none);
			drive(32'h210, i_format(6'd1, 5'd1, 5'd1, 16'h0004), vals[k], 0, none, none);
			drive(32'h214, i_format(6'd1, 5'd1, 5'd0, 16'h0004), vals[k], 0, none, none);
		end
		// jumps and links
		drive(32'h3000_0400, {6'd2, 26'h123_4567}, 0, 0, none, none);
		drive(32'h3000_0404, {6'd3, 26'h0ab_cdef}, 0, 0, none, none);
		drive(32'h500, r_format(6'h08, 5'd6, 5'd0, 5'd0, 5'd0), 32'h600, 0,
			writeback(1, 5'd6, 32'h700), none);
		drive(32'h504, r_format(6'h09, 5'd6, 5'd0, 5'd9, 5'd0), 32'h600, 0,
			none, writeback(1, 5'd6, 32'h800));
		drive(32'h508, i_format(6'd1, 5'd2, 5'd17, 16'h0008), 32'd5, 0, none, none);
		drive(32'h50c, i_format(6'd1, 5'd2, 5'd16, 16'h0008), 32'hffff_ffff, 0, none, none);
		// back-to-back random traffic
		for (int n = 0; n < N_RAND; n++) begin
			drive(32'($random(seed)) & 32'hffff_fffc, random_inst(),
				rnd(3) == 0 ? 32'd0 : 32'($random(seed)), 32'($random(seed)),
				writeback(1'(rnd(2)), 5'(rnd(4)), 32'($random(seed))),
				writeback(1'(rnd(2)), 5'(rnd(4)), 32'($random(seed))));
		end
		@(posedge clk);
		#2;
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
